// File: source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  localparam int data_width  = 32; // Word and register width
  localparam int regno_width = 4;  // 16 registers
  localparam int imm_width   = 16;

  // Primary opcode, bits 31:26
  typedef enum logic [5:0] {
    op1_alur = 6'b000000, // Register ALU ops, op2 selects
    op1_beq  = 6'b001000,
    op1_blt  = 6'b001001,
    op1_ble  = 6'b001010,
    op1_bne  = 6'b001011,
    op1_jal  = 6'b001100,
    op1_lw   = 6'b010010,
    op1_sw   = 6'b011010,
    op1_addi = 6'b100000,
    op1_andi = 6'b100100,
    op1_ori  = 6'b100101,
    op1_xori = 6'b100110
  } op1_t;

  // Secondary opcode for op1_alur
  typedef enum logic [7:0] {
    op2_eq   = 8'b00001000, // Compares give 0 or 1
    op2_lt   = 8'b00001001,
    op2_le   = 8'b00001010,
    op2_ne   = 8'b00001011,
    op2_add  = 8'b00100000,
    op2_and  = 8'b00100100,
    op2_or   = 8'b00100101,
    op2_xor  = 8'b00100110,
    op2_sub  = 8'b00101000,
    op2_nand = 8'b00101100,
    op2_nor  = 8'b00101101,
    op2_nxor = 8'b00101110,
    op2_rshf = 8'b00110000, // Arithmetic
    op2_lshf = 8'b00110001
  } op2_t;

  typedef struct packed {
    op1_t                   op1;
    op2_t                   op2;
    logic [5:0]             unused;
    logic [regno_width-1:0] rd;
    logic [regno_width-1:0] rs;
    logic [regno_width-1:0] rt;
  } r_fmt_t;

  // Rt is the destination here, except for branches and SW
  typedef struct packed {
    op1_t                   op1;
    logic [1:0]             unused;
    logic [imm_width-1:0]   imm;
    logic [regno_width-1:0] rs;
    logic [regno_width-1:0] rt;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_word_u;

  localparam logic [data_width-1:0] nop_word = '0; // Decodes as a harmless ALU op

endpackage

`default_nettype wire

// File: source/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  localparam logic [cpu_isa_pkg::data_width-1:0] start_pc  = 32'h100;
  localparam logic [cpu_isa_pkg::data_width-1:0] inst_size = 32'd4;

  localparam int imem_words = 16384; // 16-bit byte address space
  localparam int dmem_words = 16384;

  // I/O window, upper bound exclusive
  localparam logic [cpu_isa_pkg::data_width-1:0] io_base   = 32'hfffff000;
  localparam logic [cpu_isa_pkg::data_width-1:0] io_limit  = 32'hfffff120;
  localparam logic [cpu_isa_pkg::data_width-1:0] addr_hex  = 32'hfffff000;
  localparam logic [cpu_isa_pkg::data_width-1:0] addr_ledr = 32'hfffff020;

  localparam int hex_width  = 24;
  localparam int ledr_width = 10;
  localparam logic [hex_width-1:0] hex_reset = 24'hfedead;

  typedef struct packed {
    logic                                  strobe;
    logic [$clog2(imem_words)-1:0]         addr;   // Word index
    logic [cpu_isa_pkg::data_width-1:0]    data;
  } prog_wr_t;

  typedef struct packed {
    logic                                  strobe;
    logic [cpu_isa_pkg::data_width-1:0]    addr;
    logic [cpu_isa_pkg::data_width-1:0]    data;
  } io_wr_t;

  typedef struct packed {
    logic                                  taken;
    logic [cpu_isa_pkg::data_width-1:0]    target;
  } redirect_t;

  typedef struct packed {
    logic                                  valid;
    logic [cpu_isa_pkg::data_width-1:0]    pc_plus;
    cpu_isa_pkg::op1_t                     op1;
    cpu_isa_pkg::op2_t                     op2;
    logic [cpu_isa_pkg::data_width-1:0]    rs_val;
    logic [cpu_isa_pkg::data_width-1:0]    rt_val;
    logic [cpu_isa_pkg::data_width-1:0]    imm;    // Sign-extended
    logic [cpu_isa_pkg::regno_width-1:0]   wregno;
    logic                                  wr;
    logic                                  br;
    logic                                  jal;
    logic                                  ld;
    logic                                  st;
  } dec_ex_t;

  typedef struct packed {
    logic                                  valid;
    logic [cpu_isa_pkg::data_width-1:0]    result; // ALU value, address or link
    logic [cpu_isa_pkg::data_width-1:0]    st_data;
    logic [cpu_isa_pkg::regno_width-1:0]   wregno;
    logic                                  wr;
    logic                                  ld;
    logic                                  st;
  } ex_mem_t;

  typedef struct packed {
    logic                                  wr;
    logic [cpu_isa_pkg::regno_width-1:0]   wregno;
    logic [cpu_isa_pkg::data_width-1:0]    value;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  soc_map_pkg::prog_wr_t              prog,
  input  logic                               stall,
  input  logic                               hold,
  input  soc_map_pkg::redirect_t             redirect,
  output cpu_isa_pkg::inst_word_u            inst,
  output logic [cpu_isa_pkg::data_width-1:0] pc_plus,
  output logic                               valid
);

  import cpu_isa_pkg::*;
  import soc_map_pkg::*;

  logic [data_width-1:0] imem [imem_words]; // Word addressed
  logic [data_width-1:0] pc;
  logic [data_width-1:0] pc_next;           // Sequential successor
  logic [data_width-1:0] imem_rd;

  assign pc_next = pc + inst_size;
  assign imem_rd = imem[pc[$clog2(imem_words)+1:2]];

  // Load port, one word per strobe
  always_ff @(posedge clk)
  begin
    if (prog.strobe)
      imem[prog.addr] <= prog.data;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= start_pc;
    else if (redirect.taken)
      pc <= redirect.target; // Overrides hold
    else if (!stall && !hold)
      pc <= pc_next;
  end

  // Fetch-to-decode register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid   <= 1'b0;
      inst    <= nop_word;
      pc_plus <= '0;
    end
    else if (redirect.taken || (hold && !stall))
    begin
      valid <= 1'b0; // Bubble while the branch resolves
      inst  <= nop_word;
    end
    else if (!stall)
    begin
      valid   <= 1'b1;
      inst    <= imem_rd;
      pc_plus <= pc_next;
    end
  end

  // JAL takes rs as its base, so a bad base register shows up here
  pc_aligned_a : assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                                clk,
  input  logic                                reset,
  input  cpu_isa_pkg::inst_word_u             inst,
  input  logic [cpu_isa_pkg::data_width-1:0]  pc_plus,
  input  logic                                valid,
  input  logic [cpu_isa_pkg::regno_width-1:0] ex_wregno,
  input  logic [cpu_isa_pkg::regno_width-1:0] mem_wregno,
  input  logic                                ex_wr,
  input  logic                                mem_wr,
  input  soc_map_pkg::redirect_t              redirect,
  input  soc_map_pkg::mem_wb_t                wb,
  output logic                                stall,
  output logic                                hold,
  output soc_map_pkg::dec_ex_t                dec
);

  import cpu_isa_pkg::*;
  import soc_map_pkg::*;

  logic [data_width-1:0]  regs [1 << regno_width];
  op1_t                   op1;
  logic                   is_alur;
  logic                   is_br;
  logic                   is_jal;
  logic                   is_lw;
  logic                   is_sw;
  logic                   uses_rt;
  logic [regno_width-1:0] rs;
  logic [regno_width-1:0] rt;
  logic [regno_width-1:0] wregno;
  logic [imm_width-1:0]   imm;
  logic [data_width-1:0]  rs_val;
  logic [data_width-1:0]  rt_val;
  logic                   rs_hit;
  logic                   rt_hit;

  assign op1     = inst.r_fmt.op1; // Same place in both views
  assign is_alur = (op1 == op1_alur);
  assign is_br   = (op1 inside {op1_beq, op1_blt, op1_ble, op1_bne});
  assign is_jal  = (op1 == op1_jal);
  assign is_lw   = (op1 == op1_lw);
  assign is_sw   = (op1 == op1_sw);

  // Only the register form carries rd
  assign rs     = is_alur ? inst.r_fmt.rs : inst.i_fmt.rs;
  assign rt     = is_alur ? inst.r_fmt.rt : inst.i_fmt.rt;
  assign imm    = inst.i_fmt.imm;
  assign wregno = is_alur ? inst.r_fmt.rd :
                  (is_br || is_sw) ? '0 : inst.i_fmt.rt;

  // Write-through read ports
  assign rs_val = (wb.wr && wb.wregno == rs) ? wb.value : regs[rs];
  assign rt_val = (wb.wr && wb.wregno == rt) ? wb.value : regs[rt];

  // Producers still in execute or mem
  assign rs_hit  = (ex_wr && ex_wregno == rs) || (mem_wr && mem_wregno == rs);
  assign rt_hit  = (ex_wr && ex_wregno == rt) || (mem_wr && mem_wregno == rt);
  assign uses_rt = is_alur || is_br || is_sw; // Immediate, LW and JAL read rs only

  assign stall = valid && (rs_hit || (uses_rt && rt_hit));
  assign hold  = valid && (is_br || is_jal); // Fetch waits for the target

  // Register file written at the end of write-back
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < (1 << regno_width); i++)
        regs[i] <= '0;
    end
    else if (wb.wr)
      regs[wb.wregno] <= wb.value;
  end

  // Decode-to-execute register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      dec <= '0;
    else
    begin
      dec.valid   <= valid && !stall && !redirect.taken; // Bubble on hazard
      dec.pc_plus <= pc_plus;
      dec.op1     <= op1;
      dec.op2     <= inst.r_fmt.op2; // Only meaningful for op1_alur
      dec.rs_val  <= rs_val;
      dec.rt_val  <= rt_val;
      dec.imm     <= {{(data_width - imm_width){imm[imm_width-1]}}, imm};
      dec.wregno  <= wregno;
      dec.wr      <= !(is_br || is_sw);
      dec.br      <= is_br;
      dec.jal     <= is_jal;
      dec.ld      <= is_lw;
      dec.st      <= is_sw;
    end
  end

  // Fetch answers a hold with a bubble on the next edge
  hold_bubble_a : assert property (@(posedge clk) disable iff (reset)
    (hold && !stall) |=> !valid);

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  logic                                clk,
  input  logic                                reset,
  input  soc_map_pkg::dec_ex_t                dec,
  output soc_map_pkg::redirect_t              redirect,
  output soc_map_pkg::ex_mem_t                ex,
  output logic [cpu_isa_pkg::regno_width-1:0] ex_wregno,
  output logic                                ex_wr
);

  import cpu_isa_pkg::*;
  import soc_map_pkg::*;

  logic signed [data_width-1:0] a;      // rs
  logic signed [data_width-1:0] b;      // rt
  logic        [data_width-1:0] alu;
  logic        [data_width-1:0] offset; // Branch displacement in bytes
  logic                         br_cond;

  assign a      = dec.rs_val;
  assign b      = dec.rt_val;
  assign offset = dec.imm << 2;

  always_comb
  begin
    alu = '0;
    if (dec.op1 == op1_alur)
    begin
      case (dec.op2)
        op2_eq   : alu = data_width'(a == b);
        op2_lt   : alu = data_width'(a < b);  // Signed
        op2_le   : alu = data_width'(a <= b);
        op2_ne   : alu = data_width'(a != b);
        op2_add  : alu = a + b;
        op2_and  : alu = a & b;
        op2_or   : alu = a | b;
        op2_xor  : alu = a ^ b;
        op2_sub  : alu = a - b;
        op2_nand : alu = ~(a & b);
        op2_nor  : alu = ~(a | b);
        op2_nxor : alu = ~(a ^ b);
        op2_rshf : alu = a >>> b;             // Keeps the sign
        op2_lshf : alu = a << b;
        default  : alu = '0;
      endcase
    end
    else
    begin
      case (dec.op1)
        op1_addi, op1_lw, op1_sw : alu = a + dec.imm; // Also the memory address
        op1_andi : alu = a & dec.imm;
        op1_ori  : alu = a | dec.imm;
        op1_xori : alu = a ^ dec.imm;
        default  : alu = '0;
      endcase
    end
  end

  // Branch compares are signed
  always_comb
  begin
    case (dec.op1)
      op1_beq : br_cond = (a == b);
      op1_blt : br_cond = (a < b);
      op1_ble : br_cond = (a <= b);
      op1_bne : br_cond = (a != b);
      default : br_cond = 1'b0;
    endcase
  end

  always_comb
  begin
    redirect.taken  = dec.valid && (dec.jal || (dec.br && br_cond));
    redirect.target = dec.jal ? dec.rs_val + offset : dec.pc_plus + offset;
  end

  // Destination of the instruction now in execute
  assign ex_wregno = dec.wregno;
  assign ex_wr     = dec.valid && dec.wr;

  // Execute-to-memory register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex <= '0;
    else
    begin
      ex.valid   <= dec.valid;
      ex.result  <= dec.jal ? dec.pc_plus : alu; // JAL links into rt
      ex.st_data <= dec.rt_val;
      ex.wregno  <= dec.wregno;
      ex.wr      <= dec.wr;
      ex.ld      <= dec.ld;
      ex.st      <= dec.st;
    end
  end

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
  input  logic                                 clk,
  input  logic                                 reset,
  input  soc_map_pkg::ex_mem_t                 ex,
  output soc_map_pkg::mem_wb_t                 wb,
  output logic [cpu_isa_pkg::regno_width-1:0]  mem_wregno,
  output logic                                 mem_wr,
  output soc_map_pkg::io_wr_t                  io_wr,
  output logic [soc_map_pkg::hex_width-1:0]    hex,
  output logic [soc_map_pkg::ledr_width-1:0]   ledr
);

  import cpu_isa_pkg::*;
  import soc_map_pkg::*;

  logic [data_width-1:0]         dmem [dmem_words];
  logic [$clog2(dmem_words)-1:0] widx;   // Word index into dmem
  logic                          in_io;
  logic                          st_mem;
  logic                          st_io;
  logic [data_width-1:0]         ld_val;

  assign in_io  = (ex.result >= io_base) && (ex.result < io_limit);
  assign widx   = ex.result[$clog2(dmem_words)+1:2];
  assign st_mem = ex.valid && ex.st && !in_io;
  assign st_io  = ex.valid && ex.st && in_io;
  assign ld_val = in_io ? '0 : dmem[widx]; // No readable devices

  always_ff @(posedge clk)
  begin
    if (st_mem)
      dmem[widx] <= ex.st_data;
  end

  // Destination of the instruction now in mem
  assign mem_wregno = ex.wregno;
  assign mem_wr     = ex.valid && ex.wr;

  // Memory-to-writeback register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      wb <= '0;
    else
    begin
      wb.wr     <= ex.valid && ex.wr;
      wb.wregno <= ex.wregno;
      wb.value  <= ex.ld ? ld_val : ex.result;
    end
  end

  // Device write bus and the two output registers
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      io_wr <= '0;
      hex   <= hex_reset;
      ledr  <= '0;
    end
    else
    begin
      io_wr.strobe <= st_io; // One cycle per I/O store
      io_wr.addr   <= ex.result;
      io_wr.data   <= ex.st_data;
      if (st_io && ex.result == addr_hex)
        hex <= ex.st_data[hex_width-1:0];
      if (st_io && ex.result == addr_ledr)
        ledr <= ex.st_data[ledr_width-1:0];
    end
  end

  // Decode sets both flags from one opcode
  ld_st_a : assert property (@(posedge clk) disable iff (reset)
    ex.valid |-> !(ex.ld && ex.st));

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
  input  logic                               clk,
  input  logic                               reset,
  input  soc_map_pkg::prog_wr_t              prog,
  output soc_map_pkg::io_wr_t                io_wr,
  output logic [soc_map_pkg::hex_width-1:0]  hex,
  output logic [soc_map_pkg::ledr_width-1:0] ledr
);

  import cpu_isa_pkg::*;
  import soc_map_pkg::*;

  inst_word_u             inst;
  logic [data_width-1:0]  pc_plus;
  logic                   fe_valid;   // Fetch register holds an instruction
  logic                   stall;
  logic                   hold;
  redirect_t              redirect;
  dec_ex_t                dec;
  ex_mem_t                ex;
  mem_wb_t                wb;
  logic [regno_width-1:0] ex_wregno;
  logic [regno_width-1:0] mem_wregno;
  logic                   ex_wr;
  logic                   mem_wr;

  fetch_stage fetch_i (
    .clk      (clk),
    .reset    (reset),
    .prog     (prog),
    .stall    (stall),
    .hold     (hold),
    .redirect (redirect),
    .inst     (inst),
    .pc_plus  (pc_plus),
    .valid    (fe_valid)
  );

  decode_stage decode_i (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .pc_plus    (pc_plus),
    .valid      (fe_valid),
    .ex_wregno  (ex_wregno),
    .mem_wregno (mem_wregno),
    .ex_wr      (ex_wr),
    .mem_wr     (mem_wr),
    .redirect   (redirect),
    .wb         (wb),
    .stall      (stall),
    .hold       (hold),
    .dec        (dec)
  );

  execute_stage execute_i (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .redirect  (redirect),
    .ex        (ex),
    .ex_wregno (ex_wregno),
    .ex_wr     (ex_wr)
  );

  mem_stage mem_i (
    .clk        (clk),
    .reset      (reset),
    .ex         (ex),
    .wb         (wb),
    .mem_wregno (mem_wregno),
    .mem_wr     (mem_wr),
    .io_wr      (io_wr),
    .hex        (hex),
    .ledr       (ledr)
  );

endmodule

`default_nettype wire

// File: verif/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Instruction-level reference, one instruction per step, no pipeline timing
logic [data_width-1:0] model_regs [1 << regno_width];
logic [data_width-1:0] model_dmem [int]; // Keyed by word index

function automatic logic in_io_window(logic [data_width-1:0] addr);
  return (addr >= io_base) && (addr < io_limit);
endfunction

// Register-form result, selected by op2
function automatic logic [data_width-1:0] alu_result(op2_t op2, logic [data_width-1:0] a,
                                                     logic [data_width-1:0] b);
  case (op2)
    op2_eq   : return (a == b) ? 32'd1 : 32'd0;
    op2_lt   : return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // Signed
    op2_le   : return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
    op2_ne   : return (a != b) ? 32'd1 : 32'd0;
    op2_add  : return a + b;
    op2_and  : return a & b;
    op2_or   : return a | b;
    op2_xor  : return a ^ b;
    op2_sub  : return a - b;
    op2_nand : return ~(a & b);
    op2_nor  : return ~(a | b);
    op2_nxor : return ~(a ^ b);
    op2_rshf : return $signed(a) >>> b; // Sign fill
    op2_lshf : return a << b;
    default  : return '0;
  endcase
endfunction

// Walks prog_words from start_pc and queues every I/O store in order
task automatic run_model();
  inst_word_u            w;
  logic [data_width-1:0] pc;
  logic [data_width-1:0] next_pc;
  logic [data_width-1:0] a;
  logic [data_width-1:0] b;
  logic [data_width-1:0] imm;
  logic [data_width-1:0] addr;
  logic                  taken;
  logic                  done;
  int                    idx;
  int                    steps;
  foreach (model_regs[r])
    model_regs[r] = '0;
  model_dmem.delete();
  exp_q.delete();
  pc    = start_pc;
  steps = 0;
  done  = 1'b0;
  while (!done)
  begin
    idx = int'((pc - start_pc) >> 2);
    if (idx >= prog_words.size() || steps > 4 * prog_words.size())
    begin
      $display("Model left the program at pc %h", pc);
      end_with_failure();
    end
    w       = prog_words[idx];
    a       = model_regs[w.i_fmt.rs]; // rs and rt sit alike in both views
    b       = model_regs[w.i_fmt.rt];
    imm     = {{(data_width - imm_width){w.i_fmt.imm[imm_width-1]}}, w.i_fmt.imm};
    addr    = a + imm;                // LW and SW address
    next_pc = pc + inst_size;
    taken   = 1'b0;
    case (w.i_fmt.op1)
      op1_alur : model_regs[w.r_fmt.rd] = alu_result(w.r_fmt.op2, a, b);
      op1_addi : model_regs[w.i_fmt.rt] = a + imm;
      op1_andi : model_regs[w.i_fmt.rt] = a & imm;
      op1_ori  : model_regs[w.i_fmt.rt] = a | imm;
      op1_xori : model_regs[w.i_fmt.rt] = a ^ imm;
      op1_lw   : model_regs[w.i_fmt.rt] = in_io_window(addr) ? '0 : model_dmem[int'(addr[15:2])];
      op1_sw   :
      begin
        if (in_io_window(addr))
          exp_q.push_back(io_wr_t'({1'b1, addr, b}));
        else
          model_dmem[int'(addr[15:2])] = b;
      end
      op1_beq  : taken = (a == b);
      op1_blt  : taken = ($signed(a) < $signed(b));
      op1_ble  : taken = ($signed(a) <= $signed(b));
      op1_bne  : taken = (a != b);
      op1_jal  :
      begin
        model_regs[w.i_fmt.rt] = next_pc; // Link
        next_pc = a + (imm << 2);
      end
      default  :
      begin
        $display("Model met an unknown opcode at pc %h", pc);
        end_with_failure();
      end
    endcase
    if (taken)
    begin
      next_pc = pc + inst_size + (imm << 2);
      done    = (next_pc == pc); // Closing self-loop
    end
    pc = next_pc;
    steps++;
  end
endtask

`endif

// File: verif/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

  import cpu_isa_pkg::*;
  import soc_map_pkg::*;

  localparam int n_rand   = 80;  // Random block length
  localparam int n_slots  = 8;   // Scratch data words
  localparam int n_stores = 25;  // 15 HEX plus 10 LEDR dumps
  localparam int prog_aw  = $clog2(imem_words);

  logic                  clk;
  logic                  reset;
  prog_wr_t              prog;
  io_wr_t                io_wr;
  logic [hex_width-1:0]  hex;
  logic [ledr_width-1:0] ledr;

  logic [data_width-1:0] prog_words [$]; // Word 0 sits at start_pc
  io_wr_t                exp_q [$];      // Expected I/O stores in order
  io_wr_t                exp_wr;
  int                    strobe_count;
  int                    cycle_count;
  int                    cycle_limit;

  always #5 clk = ~clk; // 10 ns period

  cpu_top dut_i (
    .clk   (clk),
    .reset (reset),
    .prog  (prog),
    .io_wr (io_wr),
    .hex   (hex),
    .ledr  (ledr)
  );

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      end_with_failure();
    end
  endtask

  `include "isa_model.svh"

  function automatic int unsigned rand_below(int unsigned n);
    return $urandom % n;
  endfunction

  function automatic logic [data_width-1:0] encode_r(op2_t op2, logic [3:0] rd,
                                                     logic [3:0] rs, logic [3:0] rt);
    inst_word_u w;
    w           = '0;
    w.r_fmt.op1 = op1_alur;
    w.r_fmt.op2 = op2;
    w.r_fmt.rd  = rd;
    w.r_fmt.rs  = rs;
    w.r_fmt.rt  = rt;
    return w;
  endfunction

  function automatic logic [data_width-1:0] encode_i(op1_t op1, logic [imm_width-1:0] imm,
                                                     logic [3:0] rs, logic [3:0] rt);
    inst_word_u w;
    w           = '0;
    w.i_fmt.op1 = op1;
    w.i_fmt.imm = imm;
    w.i_fmt.rs  = rs;
    w.i_fmt.rt  = rt;
    return w;
  endfunction

  // Scratch word s sits well below the I/O window
  function automatic logic [imm_width-1:0] slot_addr(int s);
    return imm_width'(32'h400 + 16 * s);
  endfunction

  // Setup, random block, register dump and self-loop
  // Nothing writes r0
  task automatic build_program();
    op2_t        alu_ops [14] = '{op2_eq, op2_lt, op2_le, op2_ne, op2_add, op2_and, op2_or,
                                  op2_xor, op2_sub, op2_nand, op2_nor, op2_nxor, op2_rshf,
                                  op2_lshf};
    op1_t        imm_ops [4]  = '{op1_addi, op1_andi, op1_ori, op1_xori};
    op1_t        br_ops [4]   = '{op1_beq, op1_blt, op1_ble, op1_bne};
    int          first;
    int          last;        // Index of the first dump store
    int          hop;         // Words skipped by a taken branch or JAL
    int unsigned kind;
    prog_words.delete();
    for (int r = 1; r < 16; r++)
      prog_words.push_back(encode_i(op1_addi, 16'($urandom), 4'd0, 4'(r)));
    for (int s = 0; s < n_slots; s++)
      prog_words.push_back(encode_i(op1_sw, slot_addr(s), 4'd0, 4'(s + 1)));
    first = prog_words.size();
    last  = first + n_rand;
    for (int k = first; k < last; k++)
    begin
      kind = rand_below(15);
      hop  = rand_below(((last - k - 1) < 4 ? (last - k - 1) : 4) + 1);
      if (kind < 6)
        prog_words.push_back(encode_r(alu_ops[rand_below(14)], 4'(1 + rand_below(15)),
                                      4'(rand_below(16)), 4'(rand_below(16))));
      else if (kind < 9)
        prog_words.push_back(encode_i(imm_ops[rand_below(4)], 16'($urandom),
                                      4'(rand_below(16)), 4'(1 + rand_below(15))));
      else if (kind == 9)
        prog_words.push_back(encode_i(op1_lw, slot_addr(rand_below(n_slots)), 4'd0,
                                      4'(1 + rand_below(15))));
      else if (kind == 10)
        prog_words.push_back(encode_i(op1_sw, slot_addr(rand_below(n_slots)), 4'd0,
                                      4'(rand_below(16))));
      else if (kind < 14)
        prog_words.push_back(encode_i(br_ops[rand_below(4)], 16'(hop),
                                      4'(rand_below(16)), 4'(rand_below(16))));
      else // JAL through r0 makes the immediate an absolute word address
        prog_words.push_back(encode_i(op1_jal, 16'((start_pc >> 2) + 32'(k + 1 + hop)),
                                      4'd0, 4'(1 + rand_below(15))));
    end
    for (int r = 1; r < 16; r++)
      prog_words.push_back(encode_i(op1_sw, addr_hex[15:0], 4'd0, 4'(r)));
    for (int r = 1; r < 11; r++)
      prog_words.push_back(encode_i(op1_sw, addr_ledr[15:0], 4'd0, 4'(r)));
    prog_words.push_back(encode_i(op1_beq, 16'hffff, 4'd0, 4'd0)); // Parks the CPU
  endtask

  task automatic load_program();
    foreach (prog_words[i])
    begin
      @(negedge clk);
      prog.strobe = 1'b1;
      prog.addr   = prog_aw'((start_pc >> 2) + 32'(i));
      prog.data   = prog_words[i];
    end
    @(negedge clk);
    prog = '0;
  endtask

  // Each device write against the next model store
  always @(negedge clk)
  begin
    if (io_wr.strobe)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Unexpected I/O store to %h after the last expected one", io_wr.addr);
        end_with_failure();
      end
      else
      begin
        exp_wr = exp_q.pop_front();
        strobe_count++;
        check_value("io_wr.addr", io_wr.addr, exp_wr.addr);
        check_value("io_wr.data", io_wr.data, exp_wr.data);
        if (exp_wr.addr == addr_hex) // Same edge as the strobe
          check_value("hex", 32'(hex), 32'(exp_wr.data[hex_width-1:0]));
        if (exp_wr.addr == addr_ledr)
          check_value("ledr", 32'(ledr), 32'(exp_wr.data[ledr_width-1:0]));
      end
    end
  end

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    prog         = '0;
    strobe_count = 0;
    cycle_count  = 0;
    void'($urandom(32'hfb3c8c52));
    build_program();
    run_model();
    check_value("model store count", 32'(exp_q.size()), 32'(n_stores));
    cycle_limit = prog_words.size() * 8 + 100;
    load_program();            // CPU held in reset meanwhile
    repeat (4) @(negedge clk);
    check_value("io_wr.strobe", 32'(io_wr.strobe), 32'd0);
    check_value("hex", 32'(hex), 32'(hex_reset));
    check_value("ledr", 32'(ledr), 32'd0);
    reset = 1'b0;
    while (strobe_count < n_stores && cycle_count < cycle_limit)
    begin
      @(posedge clk);          // Count settles at the falling edge
      cycle_count++;
    end
    if (strobe_count < n_stores)
    begin
      $display("Timeout after %0d cycles with %0d of %0d I/O stores seen",
               cycle_count, strobe_count, n_stores);
      end_with_failure();
    end
    repeat (20) @(negedge clk); // Any store past the dump shows up here
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
source/cpu_isa_pkg.sv
source/soc_map_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_stage.sv
source/cpu_top.sv
verif/cpu_tb.sv

// File: Makefile
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build cpu_tb with Verilator and run it"
	@echo "make clean  remove $(BUILD)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
	  -f tb.f -Mdir $(BUILD) -o cpu_tb_sim
	@out=$$(./$(BUILD)/cpu_tb_sim 2>&1); echo "$$out"; \
	  echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(BUILD)
